// ==== Bender.yml ====
package:
  name: mips_pipeline

export_include_dirs:
  - include

sources:
  # RTL in compile order
  - files:
      - source/mips_pkg.sv
      - source/decoder.sv
      - source/register_file.sv
      - source/alu.sv
      - source/hazard_unit.sv
      - source/execute_stage.sv
      - source/local_memory.sv
      - source/mips_pipeline.sv
  - target: test
    files:
      - sim/tb_mips.sv

// ==== include/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define DATA_W 32
`define REG_AW 5

// ------------------------------------------------------------
// Memory sizes, in words
// ------------------------------------------------------------
`define IMEM_AW 6
`define DMEM_AW 6

// ------------------------------------------------------------
// Program counter
// ------------------------------------------------------------
`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4

`endif

// ==== sim/stim_mips.txt ====
# P <word address> <instruction word>, in hex
# S <store byte address> <store data>, in hex, in program order
P 00 20010005  # addi $1, $0, 5
P 01 2002FFFD  # addi $2, $0, -3
P 02 00221820  # add  $3, $1, $2
P 03 00432022  # sub  $4, $2, $3
P 04 AC040000  # sw   $4, 0($0)
P 05 3C051234  # lui  $5, 0x1234
P 06 34A5F0F5  # ori  $5, $5, 0xf0f5
P 07 00A43024  # and  $6, $5, $4
P 08 00C33825  # or   $7, $6, $3
P 09 AC070004  # sw   $7, 4($0)
P 0A 0041402A  # slt  $8, $2, $1
P 0B 2829FFFE  # slti $9, $1, -2
P 0C 3C0A8000  # lui  $10, 0x8000
P 0D 002A582A  # slt  $11, $1, $10
P 0E 012B6025  # or   $12, $9, $11
P 0F AC080008  # sw   $8, 8($0)
P 10 AC0C000C  # sw   $12, 12($0)
P 11 8C0D0000  # lw   $13, 0($0)
P 12 21AE0064  # addi $14, $13, 100
P 13 AC0E0010  # sw   $14, 16($0)
P 14 2000004D  # addi $0, $0, 77
P 15 00017820  # add  $15, $0, $1
P 16 AC000014  # sw   $0, 20($0)
P 17 AC0F0018  # sw   $15, 24($0)
P 18 10220001  # beq  $1, $2, +1
P 19 AC01001C  # sw   $1, 28($0)
P 1A 20100002  # addi $16, $0, 2
P 1B 12030002  # beq  $16, $3, +2
P 1C AC010020  # sw   $1, 32($0)
P 1D AC010024  # sw   $1, 36($0)
P 1E AC040028  # sw   $4, 40($0)
P 1F 08000022  # j    0x22
P 20 AC01002C  # sw   $1, 44($0)
P 21 AC010030  # sw   $1, 48($0)
P 22 AC030034  # sw   $3, 52($0)
P 23 08000023  # j    0x23
P 24 00000000  # nop
P 25 00000000  # nop
S 00000000 FFFFFFFB
S 00000004 1234F0F3
S 00000008 00000001
S 0000000C 00000000
S 00000010 0000005F
S 00000014 00000000
S 00000018 00000005
S 0000001C 00000005
S 00000028 FFFFFFFB
S 00000034 00000002

// ==== sim/tb_mips.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	localparam int DRAIN_CYCLES = 20;

	logic                clk;
	logic                reset;
	logic                run;
	logic                prog_we;
	logic [`IMEM_AW-1:0] prog_addr;
	mips_pkg::word_t     prog_data;
	mips_pkg::store_t    store;

	logic [`IMEM_AW-1:0] prog_addr_q [$];
	mips_pkg::word_t     prog_word_q [$];
	mips_pkg::word_t     exp_addr_q  [$];
	mips_pkg::word_t     exp_data_q  [$];
	int                  store_count;
	logic                stim_ready;
	integer              seed;

	mips_pipeline dut_i (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.store     (store)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// Failure handling and compare
	// ------------------------------------------------------------
	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_equal(
		input string           what,
		input mips_pkg::word_t got,
		input mips_pkg::word_t exp
	);
		if (got !== exp) begin
			$display("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// P lines load the program, S lines are the expected stores
	task automatic read_stim();
		integer          fd;
		integer          c;
		integer          n;
		mips_pkg::word_t a;
		mips_pkg::word_t d;
		fd = $fopen("sim/stim_mips.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file sim/stim_mips.txt");
			abort_run();
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != "\n" && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (c == "P" || c == "S") begin
				n = $fscanf(fd, " %h %h", a, d);
				if (n != 2) begin
					$display("Malformed line in the stimulus file");
					abort_run();
				end
				if (c == "P") begin
					prog_addr_q.push_back(a[`IMEM_AW-1:0]);
					prog_word_q.push_back(d);
				end else begin
					exp_addr_q.push_back(a);
					exp_data_q.push_back(d);
				end
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		int gap;
		seed        = 32'hb0a3_c56e;
		reset       = 1'b1;
		run         = 1'b0;
		prog_we     = 1'b0;
		prog_addr   = '0;
		prog_data   = '0;
		store_count = 0;
		stim_ready  = 1'b0;
		read_stim();
		stim_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		foreach (prog_word_q[i]) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= prog_addr_q[i];
			prog_data <= prog_word_q[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;

		gap = 1 + ($unsigned($random(seed)) % 16); // Idle before start
		repeat (gap) @(posedge clk);
		run <= 1'b1;

		wait (store_count == exp_addr_q.size());
		repeat (DRAIN_CYCLES) @(posedge clk); // Extra stores caught by monitor
		$display("All checks passed");
		$finish;
	end

	// Store trace monitor
	always @(posedge clk) begin
		if (!reset && store.valid) begin
			if (!run) begin
				$display("A store appeared while run was low");
				abort_run();
			end else if (store_count >= exp_addr_q.size()) begin
				$display("An extra store to address %h appeared after the expected ones",
					store.addr);
				abort_run();
			end else begin
				check_equal($sformatf("store %0d address", store_count), store.addr,
					exp_addr_q[store_count]);
				check_equal($sformatf("store %0d data", store_count), store.data,
					exp_data_q[store_count]);
				store_count = store_count + 1;
			end
		end
	end

	// Watchdog
	initial begin
		longint limit_ns;
		wait (stim_ready);
		limit_ns = (prog_word_q.size() + 50) * 20 * CLK_PERIOD;
		#(limit_ns);
		$display("Timeout after %0d ns, the program did not finish", limit_ns);
		abort_run();
	end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  mips_pkg::alu_op_e op,
	output mips_pkg::word_t   result,
	output logic              zero
);

	mips_pkg::word_t diff;
	logic            ovf;

	assign diff = a - b;
	// Signed overflow of a - b
	assign ovf  = (a[$high(a)] ^ b[$high(b)]) & (diff[$high(diff)] ^ a[$high(a)]);

	always_comb begin
		result = '0;
		case (op)
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR:  result = a | b;
			mips_pkg::ALU_ADD: result = a + b;
			mips_pkg::ALU_SUB: result = diff;
			mips_pkg::ALU_SLT: result[0] = diff[$high(diff)] ^ ovf;
			default:           result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder (
	input  mips_pkg::word_t instr,
	output mips_pkg::ctrl_t ctrl,
	output mips_pkg::word_t imm
);

	mips_pkg::opcode_e op;
	mips_pkg::funct_e  fn;
	logic [15:0]       imm16;

	assign op    = mips_pkg::opcode_e'(instr[31:26]);
	assign fn    = mips_pkg::funct_e'(instr[5:0]);
	assign imm16 = instr[15:0];

	// ------------------------------------------------------------
	// Control bundle
	// ------------------------------------------------------------
	always_comb begin
		ctrl = '0;
		case (op)
			mips_pkg::OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = 1'b1;
				case (fn)
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
					default: ctrl = '0; // Unsupported funct, also sll $0 NOP
				endcase
			end
			mips_pkg::OP_LW: begin
				ctrl.reg_write  = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_op     = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_SW: begin
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_op    = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = mips_pkg::ALU_SUB; // zero flag gives equality
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = mips_pkg::ALU_ADD; // LUI adds to $0
			end
			mips_pkg::OP_ORI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_SLTI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = mips_pkg::ALU_SLT;
			end
			mips_pkg::OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// Immediate forms
	always_comb begin
		case (op)
			mips_pkg::OP_ORI: imm = {16'h0000, imm16};
			mips_pkg::OP_LUI: imm = {imm16, 16'h0000};
			default:          imm = {{16{imm16[15]}}, imm16};
		endcase
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  mips_pkg::id_ex_t   id_ex,
	input  mips_pkg::fwd_sel_e fwd_a,
	input  mips_pkg::fwd_sel_e fwd_b,
	input  mips_pkg::word_t    mem_value,
	input  mips_pkg::word_t    wb_value,
	output mips_pkg::ex_mem_t  ex_mem,
	output logic               redirect_valid,
	output mips_pkg::word_t    redirect_pc
);

	mips_pkg::word_t op_a;
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_out;
	mips_pkg::word_t branch_target;
	mips_pkg::word_t jump_target;
	logic            alu_zero;
	logic            branch_taken;

	function automatic mips_pkg::word_t pick(
		input mips_pkg::fwd_sel_e sel,
		input mips_pkg::word_t    reg_val
	);
		case (sel)
			mips_pkg::FWD_MEM: return mem_value;
			mips_pkg::FWD_WB:  return wb_value;
			default:           return reg_val;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Operands and ALU
	// ------------------------------------------------------------
	always_comb begin
		op_a = pick(fwd_a, id_ex.rs_val);
		op_b = pick(fwd_b, id_ex.rt_val);
	end

	assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

	alu alu_i (
		.a      (op_a),
		.b      (alu_b),
		.op     (id_ex.ctrl.alu_op),
		.result (alu_out),
		.zero   (alu_zero)
	);

	always_comb begin
		ex_mem            = '0;
		ex_mem.alu_out    = alu_out;
		ex_mem.store_data = op_b; // Forwarded rt
		ex_mem.dest       = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
		ex_mem.reg_write  = id_ex.ctrl.reg_write;
		ex_mem.mem_write  = id_ex.ctrl.mem_write;
		ex_mem.mem_to_reg = id_ex.ctrl.mem_to_reg;
	end

	// ------------------------------------------------------------
	// Branch and jump
	// ------------------------------------------------------------
	assign branch_target  = id_ex.pc_plus4 + {id_ex.imm[$high(id_ex.imm)-2:0], 2'b00};
	assign jump_target    = {id_ex.pc_plus4[31:28], id_ex.instr_index, 2'b00};
	assign branch_taken   = id_ex.ctrl.branch && alu_zero; // SUB result zero
	assign redirect_valid = branch_taken || id_ex.ctrl.jump;
	assign redirect_pc    = id_ex.ctrl.jump ? jump_target : branch_target;

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  mips_pkg::reg_addr_t id_rs,
	input  mips_pkg::reg_addr_t id_rt,
	input  mips_pkg::id_ex_t    id_ex,
	input  mips_pkg::ex_mem_t   ex_mem,
	input  mips_pkg::mem_wb_t   mem_wb,
	input                       redirect_valid,
	output mips_pkg::fwd_sel_e  fwd_a,
	output mips_pkg::fwd_sel_e  fwd_b,
	output logic                stall,
	output logic                flush
);

	logic load_in_ex;

	// ------------------------------------------------------------
	// Forwarding for the instruction in EX
	// ------------------------------------------------------------
	function automatic mips_pkg::fwd_sel_e fwd_for(input mips_pkg::reg_addr_t src);
		if (ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == src)
			return mips_pkg::FWD_MEM; // Youngest value wins
		else if (mem_wb.reg_write && mem_wb.dest != '0 && mem_wb.dest == src)
			return mips_pkg::FWD_WB;
		else
			return mips_pkg::FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = fwd_for(id_ex.rs);
		fwd_b = fwd_for(id_ex.rt);
	end

	// ------------------------------------------------------------
	// Load-use and redirect
	// ------------------------------------------------------------
	assign load_in_ex = id_ex.ctrl.mem_to_reg && id_ex.ctrl.reg_write;

	always_comb begin
		stall = 1'b0;
		if (load_in_ex && id_ex.rt != '0) begin
			stall = (id_ex.rt == id_rs) || (id_ex.rt == id_rt);
		end
	end

	assign flush = redirect_valid;

	// A load and a branch or jump never share EX
	a_no_stall_flush: assert final (!(stall && flush));

endmodule

// ==== source/local_memory.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module local_memory #(
	parameter int ADDR_W = `IMEM_AW
) (
	input                     clk,
	input                     we,
	input  [ADDR_W-1:0]       waddr,
	input  [ADDR_W-1:0]       raddr,
	input  mips_pkg::word_t   wdata,
	output mips_pkg::word_t   rdata
);

	mips_pkg::word_t mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr]; // Same-cycle read

endmodule

// ==== source/mips_pipeline.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_pipeline (
	input                        clk,
	input                        reset,
	input                        run,
	input                        prog_we,
	input        [`IMEM_AW-1:0]  prog_addr,
	input  mips_pkg::word_t      prog_data,
	output mips_pkg::store_t     store
);

	mips_pkg::word_t    pc;
	mips_pkg::word_t    pc_plus4;
	mips_pkg::word_t    fetch_instr;
	mips_pkg::word_t    id_instr;
	mips_pkg::word_t    id_pc_plus4;
	mips_pkg::ctrl_t    id_ctrl;
	mips_pkg::word_t    id_imm;
	mips_pkg::word_t    id_rs_val;
	mips_pkg::word_t    id_rt_val;
	mips_pkg::id_ex_t   id_next;
	mips_pkg::id_ex_t   id_ex;
	mips_pkg::ex_mem_t  ex_next;
	mips_pkg::ex_mem_t  ex_mem;
	mips_pkg::mem_wb_t  wb_next;
	mips_pkg::mem_wb_t  mem_wb;
	mips_pkg::word_t    load_data;
	mips_pkg::word_t    redirect_pc;
	mips_pkg::fwd_sel_e fwd_a;
	mips_pkg::fwd_sel_e fwd_b;
	logic               redirect_valid;
	logic               stall;
	logic               flush;
	logic               hold;

	// ------------------------------------------------------------
	// Fetch
	// ------------------------------------------------------------
	assign pc_plus4 = pc + `PC_STEP;

	local_memory #(.ADDR_W(`IMEM_AW)) imem_i (
		.clk   (clk),
		.we    (prog_we),
		.waddr (prog_addr),
		.raddr (pc[`IMEM_AW+1:2]),
		.wdata (prog_data),
		.rdata (fetch_instr)
	);

	// ------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------
	decoder decoder_i (.instr(id_instr), .ctrl(id_ctrl), .imm(id_imm));

	register_file register_file_i (
		.clk    (clk),
		.reset  (reset),
		.rs     (id_instr[25:21]),
		.rt     (id_instr[20:16]),
		.we     (mem_wb.reg_write),
		.wa     (mem_wb.dest),
		.wd     (mem_wb.result),
		.rs_val (id_rs_val),
		.rt_val (id_rt_val)
	);

	always_comb begin
		id_next             = '0;
		id_next.pc_plus4    = id_pc_plus4;
		id_next.instr_index = id_instr[25:0];
		id_next.rs_val      = id_rs_val;
		id_next.rt_val      = id_rt_val;
		id_next.imm         = id_imm;
		id_next.rs          = id_instr[25:21];
		id_next.rt          = id_instr[20:16];
		id_next.rd          = id_instr[15:11];
		id_next.ctrl        = id_ctrl;
	end

	hazard_unit hazard_unit_i (
		.id_rs          (id_instr[25:21]),
		.id_rt          (id_instr[20:16]),
		.id_ex          (id_ex),
		.ex_mem         (ex_mem),
		.mem_wb         (mem_wb),
		.redirect_valid (redirect_valid),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.stall          (stall),
		.flush          (flush)
	);

	assign hold = stall || !run; // Idle behaves like a stall

	// ------------------------------------------------------------
	// Execute, memory, write-back
	// ------------------------------------------------------------
	execute_stage execute_stage_i (
		.id_ex          (id_ex),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.mem_value      (ex_mem.alu_out),
		.wb_value       (mem_wb.result),
		.ex_mem         (ex_next),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	local_memory #(.ADDR_W(`DMEM_AW)) dmem_i (
		.clk   (clk),
		.we    (ex_mem.mem_write),
		.waddr (ex_mem.alu_out[`DMEM_AW+1:2]),
		.raddr (ex_mem.alu_out[`DMEM_AW+1:2]),
		.wdata (ex_mem.store_data),
		.rdata (load_data)
	);

	assign wb_next.result    = ex_mem.mem_to_reg ? load_data : ex_mem.alu_out;
	assign wb_next.dest      = ex_mem.dest;
	assign wb_next.reg_write = ex_mem.reg_write;

	assign store.valid = ex_mem.mem_write;
	assign store.addr  = ex_mem.alu_out;
	assign store.data  = ex_mem.store_data;

	// ------------------------------------------------------------
	// PC and pipeline registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc          <= `RESET_PC;
			id_instr    <= '0;
			id_pc_plus4 <= '0;
			id_ex       <= '0;
			ex_mem      <= '0;
			mem_wb      <= '0;
		end else begin
			ex_mem <= ex_next;
			mem_wb <= wb_next;
			if (flush) begin
				pc          <= redirect_pc; // Drop the two younger instructions
				id_instr    <= '0;
				id_pc_plus4 <= '0;
				id_ex       <= '0;
			end else if (hold) begin
				id_ex <= '0;
			end else begin
				pc          <= pc_plus4;
				id_instr    <= fetch_instr;
				id_pc_plus4 <= pc_plus4;
				id_ex       <= id_next;
			end
		end
	end

	// Program load only while the core is idle
	a_prog_idle: assert property (@(posedge clk) disable iff (reset) prog_we |-> !run);

endmodule

// ==== source/mips_pkg.sv ====
`include "mips_settings.svh"

package mips_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_ORI   = 6'b001101,
		OP_LUI   = 6'b001111,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010
	} funct_e;

	typedef enum logic [2:0] {
		ALU_AND = 3'd0,
		ALU_OR  = 3'd1,
		ALU_ADD = 3'd2,
		ALU_SUB = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_e;

	// All zero is a NOP
	typedef struct packed {
		logic    reg_write;
		logic    reg_dst; // rd instead of rt
		logic    alu_src; // Immediate as ALU operand b
		logic    mem_write;
		logic    mem_to_reg;
		logic    branch;
		logic    jump;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t addr;
		word_t data;
	} store_t;

	typedef struct packed {
		word_t       pc_plus4;
		logic [25:0] instr_index; // Jump field
		word_t       rs_val;
		word_t       rt_val;
		word_t       imm;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		ctrl_t       ctrl;
	} id_ex_t;

	typedef struct packed {
		word_t     alu_out;
		word_t     store_data;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_write;
		logic      mem_to_reg;
	} ex_mem_t;

	typedef struct packed {
		word_t     result; // Load data or ALU result
		reg_addr_t dest;
		logic      reg_write;
	} mem_wb_t;

endpackage

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input                       clk,
	input                       reset,
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	input                       we,
	input  mips_pkg::reg_addr_t wa,
	input  mips_pkg::word_t     wd,
	output mips_pkg::word_t     rs_val,
	output mips_pkg::word_t     rt_val
);

	mips_pkg::word_t regs [1:31]; // $0 has no storage

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Write in the same cycle bypasses the array
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (we && addr == wa)
			return wd;
		else
			return regs[addr];
	endfunction

	always_comb begin
		rs_val = read_port(rs);
		rt_val = read_port(rt);
	end

	a_wd_known: assert property (@(posedge clk) disable iff (reset) we |-> !$isunknown(wd));

endmodule

// ==== src.f ====
+incdir+include
source/mips_pkg.sv
source/decoder.sv
source/register_file.sv
source/alu.sv
source/hazard_unit.sv
source/execute_stage.sv
source/local_memory.sv
source/mips_pipeline.sv
sim/tb_mips.sv
